// ==== src/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Instruction classes, taken from instr[31:30].
`define CLASS_ARITH    2'b00
`define CLASS_BRANCH   2'b01
`define CLASS_MEM      2'b10
`define CLASS_MISC     2'b11

// Opcodes, taken from instr[29:26].
// The arithmetic opcodes double as ALU operation codes.
`define OPCODE_ADD     4'd0
`define OPCODE_SUB     4'd1
`define OPCODE_AND     4'd2
`define OPCODE_OR      4'd3
`define OPCODE_XOR     4'd4
`define OPCODE_LSL     4'd5
`define OPCODE_LSR     4'd6
`define OPCODE_CMP     4'd7
`define OPCODE_MOV     4'd8
`define OPCODE_BNE     4'd1
`define OPCODE_BEQ     4'd2
`define OPCODE_BGT     4'd3
`define OPCODE_BLT     4'd4
`define OPCODE_CALL    4'd5
`define OPCODE_MOVHI   4'd10
`define OPCODE_ORLO    4'd11

// ALU code that passes operand 1 straight through.
`define ALU_PASS_RA    4'd15

// Branch conditions carried in the control bundle.
`define COND_NONE      3'd0
`define COND_NE        3'd1
`define COND_EQ        3'd2
`define COND_GT        3'd3
`define COND_LT        3'd4
`define COND_ALWAYS    3'd7

// Memory access widths as presented on the request port.
`define WIDTH_BYTE     2'd0
`define WIDTH_HALF     2'd1
`define WIDTH_WORD     2'd2

// Register written with the return address by a call.
`define LINK_REG       4'd14

`endif

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	// ====================
	// Scalar types
	// ====================

	// A data word or a byte address.
	typedef logic [31:0] word_t;
	// Index into the 16-entry register file.
	typedef logic [3:0] reg_sel_t;
	// ALU operation code.
	typedef logic [3:0] alu_opc_t;
	// Branch condition code.
	typedef logic [2:0] cond_t;
	// Memory access width code.
	typedef logic [1:0] mem_width_t;
	// Instruction class from the top two bits.
	typedef logic [1:0] iclass_t;

	// ====================
	// Stage bundles
	// ====================

	// Registered control bundle handed from decode to execute.
	// The strobes in here are only ever set for a valid instruction.
	typedef struct packed {
		reg_sel_t   rd_sel;
		logic       update_rd;
		word_t      imm32;
		alu_opc_t   alu_opc;
		cond_t      branch_condition;
		logic       alu_op1_ra;
		logic       alu_op1_rb;
		logic       alu_op2_rb;
		logic       mem_load;
		logic       mem_store;
		mem_width_t mem_width;
		word_t      pc_plus_4;
		iclass_t    instr_class;
		logic       is_call;
		logic       update_flags;
	} decode_ctl_t;

	// Register writeback.
	typedef struct packed {
		logic     valid;
		reg_sel_t sel;
		word_t    data;
	} wb_t;

	// Memory request; load and store are one-cycle strobes.
	typedef struct packed {
		logic       load;
		logic       store;
		mem_width_t width;
		word_t      addr;
		word_t      wdata;
	} mem_req_t;

	// Compare flags.
	typedef struct packed {
		logic z;
		logic gt;
	} flags_t;

endpackage

// ==== src/cpu_decode.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_decode (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 instr_valid,
	input  cpu_pkg::word_t       instr,
	input  cpu_pkg::word_t       pc_plus_4,
	output cpu_pkg::reg_sel_t    ra_sel,
	output cpu_pkg::reg_sel_t    rb_sel,
	output cpu_pkg::decode_ctl_t ctl
);

	// ====================
	// Field extraction
	// ====================

	cpu_pkg::iclass_t iclass;
	logic [3:0] opcode;
	cpu_pkg::word_t imm13;
	cpu_pkg::word_t imm16;
	cpu_pkg::word_t imm24;
	logic is_arith;
	logic is_branch;
	logic is_mem;
	logic is_movhi;
	logic is_orlo;
	logic is_call;
	logic branch_ra;
	cpu_pkg::decode_ctl_t ctl_d;

	assign iclass = instr[31:30];
	assign opcode = instr[29:26];

	// Sign-extended immediates.
	// The branch offset counts words, so it is shifted left by two.
	assign imm13 = {{19{instr[24]}}, instr[24:12]};
	assign imm16 = {{16{instr[25]}}, instr[25:10]};
	assign imm24 = {{6{instr[23]}}, instr[23:0], 2'b00};

	// Register selects go to the register file without a register stage.
	assign ra_sel = instr[11:8];
	assign rb_sel = instr[7:4];

	assign is_arith  = (iclass == `CLASS_ARITH);
	assign is_branch = (iclass == `CLASS_BRANCH);
	assign is_mem    = (iclass == `CLASS_MEM);
	assign is_movhi  = (iclass == `CLASS_MISC) && (opcode == `OPCODE_MOVHI);
	assign is_orlo   = (iclass == `CLASS_MISC) && (opcode == `OPCODE_ORLO);
	assign is_call   = is_branch && (opcode == `OPCODE_CALL);
	// Bit 25 turns a branch into a branch to the address held in Ra.
	assign branch_ra = is_branch && instr[25];

	// ====================
	// Next control bundle
	// ====================

	always_comb begin
		ctl_d = '0;

		// A branch to Ra just passes Ra through the ALU as the target.
		if (is_arith || is_movhi || is_orlo) begin
			ctl_d.alu_opc = opcode;
		end else if (branch_ra) begin
			ctl_d.alu_opc = `ALU_PASS_RA;
		end else begin
			ctl_d.alu_opc = `OPCODE_ADD;
		end

		// Branches add imm24 to PC+4, movhi loads the upper half.
		if (is_branch) begin
			ctl_d.imm32 = imm24;
		end else if (is_movhi) begin
			ctl_d.imm32 = {imm16[15:0], 16'h0000};
		end else if (is_orlo) begin
			ctl_d.imm32 = {16'h0000, imm16[15:0]};
		end else begin
			ctl_d.imm32 = imm13;
		end

		// Operand 1 defaults to PC+4 when neither register is chosen.
		ctl_d.alu_op1_ra = is_arith || is_mem || branch_ra;
		ctl_d.alu_op1_rb = is_orlo;
		ctl_d.alu_op2_rb = is_arith && instr[25];

		// Width field 00 is word, 01 is half, anything else is byte.
		case (instr[27:26])
			2'b00:   ctl_d.mem_width = `WIDTH_WORD;
			2'b01:   ctl_d.mem_width = `WIDTH_HALF;
			default: ctl_d.mem_width = `WIDTH_BYTE;
		endcase

		ctl_d.rd_sel      = is_call ? `LINK_REG : instr[3:0];
		ctl_d.pc_plus_4   = pc_plus_4;
		ctl_d.instr_class = iclass;

		// Everything below has a side effect, so it needs a valid instruction.
		if (instr_valid) begin
			ctl_d.update_rd = (is_arith && (opcode != `OPCODE_CMP)) ||
				is_movhi || is_orlo || is_call;
			ctl_d.update_flags = is_arith && (opcode == `OPCODE_CMP);
			ctl_d.mem_load     = is_mem && !instr[28];
			ctl_d.mem_store    = is_mem && instr[28];
			ctl_d.is_call      = is_call;
			if (is_branch) begin
				case (opcode)
					`OPCODE_BNE: ctl_d.branch_condition = `COND_NE;
					`OPCODE_BEQ: ctl_d.branch_condition = `COND_EQ;
					`OPCODE_BGT: ctl_d.branch_condition = `COND_GT;
					`OPCODE_BLT: ctl_d.branch_condition = `COND_LT;
					default:     ctl_d.branch_condition = `COND_ALWAYS;
				endcase
			end
		end
	end

	// The whole bundle is registered so it lines up with the register reads.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctl <= '0;
		end else begin
			ctl <= ctl_d;
		end
	end

	// A valid strobe with unknown instruction bits would decode unknown strobes.
	assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid |-> !$isunknown(instr));

endmodule

// ==== src/cpu_regfile.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_regfile (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::reg_sel_t ra_sel,
	input  cpu_pkg::reg_sel_t rb_sel,
	input  cpu_pkg::wb_t      wb,
	output cpu_pkg::word_t    ra_data,
	output cpu_pkg::word_t    rb_data,
	output cpu_pkg::reg_sel_t ra_sel_q,
	output cpu_pkg::reg_sel_t rb_sel_q
);

	cpu_pkg::word_t regs [16];

	// The write lands one edge after execute presents it on wb.
	// A read of the same register on that edge sees the new value.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
			ra_data  <= '0;
			rb_data  <= '0;
			ra_sel_q <= '0;
			rb_sel_q <= '0;
		end else begin
			if (wb.valid) begin
				regs[wb.sel] <= wb.data;
			end
			ra_data  <= (wb.valid && (wb.sel == ra_sel)) ? wb.data : regs[ra_sel];
			rb_data  <= (wb.valid && (wb.sel == rb_sel)) ? wb.data : regs[rb_sel];
			// Execute compares these against its own wb for forwarding.
			ra_sel_q <= ra_sel;
			rb_sel_q <= rb_sel;
		end
	end

	// An unknown select during a write would corrupt an unknown register.
	assert property (@(posedge clk) disable iff (!rst_n)
		wb.valid |-> !$isunknown(wb.sel));

endmodule

// ==== src/cpu_execute.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_execute (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_pkg::decode_ctl_t ctl,
	input  cpu_pkg::word_t       ra_data,
	input  cpu_pkg::word_t       rb_data,
	input  cpu_pkg::reg_sel_t    ra_sel_q,
	input  cpu_pkg::reg_sel_t    rb_sel_q,
	output cpu_pkg::wb_t         wb,
	output cpu_pkg::flags_t      flags,
	output logic                 branch_taken,
	output cpu_pkg::word_t       branch_target,
	output cpu_pkg::mem_req_t    mem
);

	cpu_pkg::word_t ra_val;
	cpu_pkg::word_t rb_val;
	cpu_pkg::word_t op1;
	cpu_pkg::word_t op2;
	cpu_pkg::word_t alu_result;
	cpu_pkg::flags_t cmp_flags;
	logic taken;

	// ====================
	// Operands
	// ====================

	// The previous instruction's result is not in the register file yet.
	// Take it from our own wb register when the selects match.
	assign ra_val = (wb.valid && (wb.sel == ra_sel_q)) ? wb.data : ra_data;
	assign rb_val = (wb.valid && (wb.sel == rb_sel_q)) ? wb.data : rb_data;

	assign op1 = ctl.alu_op1_ra ? ra_val :
		ctl.alu_op1_rb ? rb_val : ctl.pc_plus_4;
	assign op2 = ctl.alu_op2_rb ? rb_val : ctl.imm32;

	// ====================
	// ALU
	// ====================

	always_comb begin
		case (ctl.alu_opc)
			`OPCODE_ADD:   alu_result = op1 + op2;
			`OPCODE_SUB:   alu_result = op1 - op2;
			`OPCODE_AND:   alu_result = op1 & op2;
			`OPCODE_OR:    alu_result = op1 | op2;
			`OPCODE_XOR:   alu_result = op1 ^ op2;
			`OPCODE_LSL:   alu_result = op1 << op2[4:0];
			`OPCODE_LSR:   alu_result = op1 >> op2[4:0];
			`OPCODE_CMP:   alu_result = op1 - op2;
			`OPCODE_MOV:   alu_result = op2;
			`OPCODE_MOVHI: alu_result = op2;
			`OPCODE_ORLO:  alu_result = op1 | op2;
			`ALU_PASS_RA:  alu_result = op1;
			default:       alu_result = '0;
		endcase
	end

	// Compare flags are computed on the raw operands, not the result.
	assign cmp_flags.z  = (op1 == op2);
	assign cmp_flags.gt = $signed(op1) > $signed(op2);

	// ====================
	// Branch decision
	// ====================

	// Conditions test the flags register, which a cmp issued just before
	// has already updated by the time the branch gets here.
	always_comb begin
		taken = 1'b0;
		if (ctl.instr_class == `CLASS_BRANCH) begin
			case (ctl.branch_condition)
				`COND_NE:     taken = !flags.z;
				`COND_EQ:     taken = flags.z;
				`COND_GT:     taken = flags.gt;
				`COND_LT:     taken = !flags.z && !flags.gt;
				`COND_ALWAYS: taken = 1'b1;
				default:      taken = 1'b0;
			endcase
		end
	end

	// ====================
	// Output registers
	// ====================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb            <= '0;
			flags         <= '0;
			branch_taken  <= 1'b0;
			branch_target <= '0;
			mem           <= '0;
		end else begin
			// A call links PC+4 while the ALU produces the target.
			wb.valid <= ctl.update_rd;
			wb.sel   <= ctl.rd_sel;
			wb.data  <= ctl.is_call ? ctl.pc_plus_4 : alu_result;
			if (ctl.update_flags) begin
				flags <= cmp_flags;
			end
			branch_taken  <= taken;
			branch_target <= alu_result;
			// For memory instructions the ALU adds Ra and imm13.
			mem.load  <= ctl.mem_load;
			mem.store <= ctl.mem_store;
			mem.width <= ctl.mem_width;
			mem.addr  <= alu_result;
			mem.wdata <= rb_val;
		end
	end

	// Decode never marks one instruction as both a branch and an access.
	assert property (@(posedge clk) disable iff (!rst_n)
		!(branch_taken && (mem.load || mem.store)));

endmodule

// ==== src/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  cpu_pkg::word_t    instr,
	input  cpu_pkg::word_t    pc_plus_4,
	output cpu_pkg::wb_t      wb,
	output cpu_pkg::flags_t   flags,
	output logic              branch_taken,
	output cpu_pkg::word_t    branch_target,
	output cpu_pkg::mem_req_t mem
);

	// Decode drives the read selects straight into the register file.
	cpu_pkg::reg_sel_t ra_sel;
	cpu_pkg::reg_sel_t rb_sel;
	// These all change on the same edge and stay aligned into execute.
	cpu_pkg::decode_ctl_t ctl;
	cpu_pkg::word_t ra_data;
	cpu_pkg::word_t rb_data;
	cpu_pkg::reg_sel_t ra_sel_q;
	cpu_pkg::reg_sel_t rb_sel_q;

	cpu_decode decode_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc_plus_4   (pc_plus_4),
		.ra_sel      (ra_sel),
		.rb_sel      (rb_sel),
		.ctl         (ctl)
	);

	// The writeback port loops from execute back into the register file.
	cpu_regfile regfile_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ra_sel   (ra_sel),
		.rb_sel   (rb_sel),
		.wb       (wb),
		.ra_data  (ra_data),
		.rb_data  (rb_data),
		.ra_sel_q (ra_sel_q),
		.rb_sel_q (rb_sel_q)
	);

	cpu_execute execute_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.ctl           (ctl),
		.ra_data       (ra_data),
		.rb_data       (rb_data),
		.ra_sel_q      (ra_sel_q),
		.rb_sel_q      (rb_sel_q),
		.wb            (wb),
		.flags         (flags),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.mem           (mem)
	);

endmodule

// ==== verification/tb_cpu_model.svh ====
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

`include "cpu_config.svh"

// Outputs that the DUT should show two edges after an instruction is driven.
typedef struct packed {
	cpu_pkg::wb_t      wb;
	cpu_pkg::flags_t   flags;
	logic              branch_taken;
	cpu_pkg::word_t    branch_target;
	cpu_pkg::mem_req_t mem;
} expected_t;

// Instruction kinds for the generator.
localparam int KIND_ARITH  = 0;
localparam int KIND_MISC   = 1;
localparam int KIND_CMP    = 2;
localparam int KIND_MEM    = 3;
localparam int KIND_BRANCH = 4;

// ====================
// Model state
// ====================

cpu_pkg::word_t  model_regs [16];
cpu_pkg::flags_t model_flags;
// Address of the last issued instruction; the stream is straight-line code.
cpu_pkg::word_t  model_pc;
logic [31:0]     rng_state;

// 32-bit xorshift step with shifts 13, 17 and 5.
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [31:0] rand32();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

function automatic void reset_model();
	for (int i = 0; i < 16; i++) begin
		model_regs[i] = '0;
	end
	model_flags = '0;
	model_pc = 32'h0000_1000;
endfunction

// Idle cycle: no strobes, flags hold what the last compare left.
function automatic expected_t bubble_expect();
	expected_t e;
	e = '0;
	e.flags = model_flags;
	return e;
endfunction

// ====================
// Sequential interpreter
// ====================

// Executes one instruction on the model state and returns what the DUT should show.
function automatic expected_t run_model(input cpu_pkg::word_t word);
	expected_t e;
	cpu_pkg::word_t pc4;
	cpu_pkg::word_t ra_v;
	cpu_pkg::word_t rb_v;
	cpu_pkg::word_t imm13;
	cpu_pkg::word_t src2;
	cpu_pkg::word_t result;
	logic [3:0] opc;
	logic write_rd;
	e = '0;
	pc4 = model_pc + 32'd4;
	opc = word[29:26];
	ra_v = model_regs[word[11:8]];
	rb_v = model_regs[word[7:4]];
	imm13 = {{19{word[24]}}, word[24:12]};
	result = '0;
	write_rd = 1'b0;
	e.wb.sel = word[3:0];
	case (word[31:30])
		`CLASS_ARITH: begin
			src2 = word[25] ? rb_v : imm13;
			write_rd = 1'b1;
			case (opc)
				`OPCODE_ADD: result = ra_v + src2;
				`OPCODE_SUB: result = ra_v - src2;
				`OPCODE_AND: result = ra_v & src2;
				`OPCODE_OR:  result = ra_v | src2;
				`OPCODE_XOR: result = ra_v ^ src2;
				`OPCODE_LSL: result = ra_v << src2[4:0];
				`OPCODE_LSR: result = ra_v >> src2[4:0];
				`OPCODE_MOV: result = src2;
				`OPCODE_CMP: begin
					// A compare only touches the flags.
					write_rd = 1'b0;
					model_flags.z  = (ra_v == src2);
					model_flags.gt = ($signed(ra_v) > $signed(src2));
				end
				default: result = '0;
			endcase
		end
		`CLASS_BRANCH: begin
			if (word[25]) begin
				e.branch_target = ra_v;
			end else begin
				e.branch_target = pc4 + {{6{word[23]}}, word[23:0], 2'b00};
			end
			case (opc)
				`OPCODE_BNE: e.branch_taken = !model_flags.z;
				`OPCODE_BEQ: e.branch_taken = model_flags.z;
				`OPCODE_BGT: e.branch_taken = model_flags.gt;
				`OPCODE_BLT: e.branch_taken = !model_flags.z && !model_flags.gt;
				default:     e.branch_taken = 1'b1;
			endcase
			// The return address goes to the link register.
			if (opc == `OPCODE_CALL) begin
				write_rd = 1'b1;
				e.wb.sel = `LINK_REG;
				result = pc4;
			end
		end
		`CLASS_MEM: begin
			e.mem.load  = !word[28];
			e.mem.store = word[28];
			case (word[27:26])
				2'b00:   e.mem.width = `WIDTH_WORD;
				2'b01:   e.mem.width = `WIDTH_HALF;
				default: e.mem.width = `WIDTH_BYTE;
			endcase
			e.mem.addr  = ra_v + imm13;
			e.mem.wdata = rb_v;
		end
		default: begin
			// Miscellaneous class; orlo merges the low half into Rb.
			if (opc == `OPCODE_MOVHI) begin
				write_rd = 1'b1;
				result = {word[25:10], 16'h0000};
			end else if (opc == `OPCODE_ORLO) begin
				write_rd = 1'b1;
				result = rb_v | {16'h0000, word[25:10]};
			end
		end
	endcase
	if (write_rd) begin
		e.wb.valid = 1'b1;
		e.wb.data = result;
		model_regs[e.wb.sel] = result;
	end
	e.flags = model_flags;
	model_pc = pc4;
	return e;
endfunction

// ====================
// Instruction generators
// ====================

function automatic cpu_pkg::word_t gen_instr(input int kind);
	cpu_pkg::word_t w;
	w = rand32();
	// Half the time the register fields are narrowed to r0..r3, so that
	// neighbouring instructions share registers and hit the forwarding.
	if (rand32() % 2 == 0) begin
		w[11:10] = 2'b00;
		w[7:6] = 2'b00;
		w[3:2] = 2'b00;
	end
	case (kind)
		KIND_ARITH: w[31:26] = {`CLASS_ARITH, 4'(rand32() % 9)};
		KIND_MISC:  w[31:26] = {`CLASS_MISC,
			(rand32() % 2 == 0) ? `OPCODE_MOVHI : `OPCODE_ORLO};
		KIND_CMP: begin
			w[31:26] = {`CLASS_ARITH, `OPCODE_CMP};
			// A register compared with itself gives an equal result.
			if (rand32() % 4 == 0) begin
				w[25] = 1'b1;
				w[7:4] = w[11:8];
			end
		end
		KIND_MEM: w[31:30] = `CLASS_MEM;
		default:  w[31:30] = `CLASS_BRANCH;
	endcase
	return w;
endfunction

function automatic cpu_pkg::word_t gen_branch(input logic [3:0] opc, input logic to_ra);
	cpu_pkg::word_t w;
	w = gen_instr(KIND_BRANCH);
	w[29:26] = opc;
	w[25] = to_ra;
	return w;
endfunction

// Mixed stream, weighted toward register-writing instructions.
function automatic cpu_pkg::word_t gen_mixed();
	cpu_pkg::word_t w;
	int pick;
	pick = int'(rand32() % 8);
	case (pick)
		0, 1, 2: w = gen_instr(KIND_ARITH);
		3:       w = gen_instr(KIND_MISC);
		4:       w = gen_instr(KIND_CMP);
		5:       w = gen_instr(KIND_MEM);
		default: w = gen_instr(KIND_BRANCH);
	endcase
	return w;
endfunction

`endif

// ==== verification/tb_cpu_core.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu_core;

	localparam int MAX_CYCLES = 10000;

	logic clk;
	logic rst_n;
	logic instr_valid;
	cpu_pkg::word_t instr;
	cpu_pkg::word_t pc_plus_4;
	cpu_pkg::wb_t wb;
	cpu_pkg::flags_t flags;
	logic branch_taken;
	cpu_pkg::word_t branch_target;
	cpu_pkg::mem_req_t mem;

	int check_count;
	int error_count;
	int test_errors;

	`include "tb_cpu_model.svh"

	// Expected outputs in flight; pipe[1] is due at the current falling edge.
	expected_t pipe [2];

	cpu_core dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.pc_plus_4     (pc_plus_4),
		.wb            (wb),
		.flags         (flags),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.mem           (mem)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Stops a run that never reaches its end.
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		check_count++;
		if (act_val !== exp_val) begin
			error_count++;
			test_errors++;
			$display("Fail time=%0t signal=%s expected=%h actual=%h",
				$time, name, exp_val, act_val);
		end
	endtask

	// Data fields are only compared when their strobe is expected high.
	task automatic compare_outputs(input expected_t e);
		check("wb.valid", 32'(e.wb.valid), 32'(wb.valid));
		if (e.wb.valid) begin
			check("wb.sel", 32'(e.wb.sel), 32'(wb.sel));
			check("wb.data", e.wb.data, wb.data);
		end
		check("flags.z", 32'(e.flags.z), 32'(flags.z));
		check("flags.gt", 32'(e.flags.gt), 32'(flags.gt));
		check("branch_taken", 32'(e.branch_taken), 32'(branch_taken));
		if (e.branch_taken) begin
			check("branch_target", e.branch_target, branch_target);
		end
		check("mem.load", 32'(e.mem.load), 32'(mem.load));
		check("mem.store", 32'(e.mem.store), 32'(mem.store));
		if (e.mem.load || e.mem.store) begin
			check("mem.width", 32'(e.mem.width), 32'(mem.width));
			check("mem.addr", e.mem.addr, mem.addr);
			check("mem.wdata", e.mem.wdata, mem.wdata);
		end
	endtask

	// One clock: check what is due, then drive the next input on the falling edge.
	task automatic step(input logic valid, input cpu_pkg::word_t word);
		@(negedge clk);
		compare_outputs(pipe[1]);
		pipe[1] = pipe[0];
		instr_valid = valid;
		instr = word;
		pc_plus_4 = model_pc + 32'd4;
		if (valid) begin
			pipe[0] = run_model(word);
		end else begin
			pipe[0] = bubble_expect();
		end
	endtask

	// About one cycle in five is a bubble carrying a junk instruction word.
	task automatic issue(input cpu_pkg::word_t word);
		while (rand32() % 5 == 0) begin
			step(1'b0, rand32());
		end
		step(1'b1, word);
	endtask

	// Drains the pipeline so a test's own errors are counted against it.
	task automatic finish_test(input string name);
		step(1'b0, '0);
		step(1'b0, '0);
		$display("%s finished with %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	initial begin : main
		cpu_pkg::word_t w;
		cpu_pkg::word_t br;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc_plus_4 = '0;
		check_count = 0;
		error_count = 0;
		test_errors = 0;
		rng_state = 32'd83850;
		reset_model();
		pipe[0] = bubble_expect();
		pipe[1] = bubble_expect();
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
		end
		rst_n = 1'b1;

		// Idle after reset: every strobe and both flags low.
		for (int i = 0; i < 4; i++) begin
			step(1'b0, rand32());
		end
		finish_test("test 1 reset state");

		for (int i = 0; i < 300; i++) begin
			if (rand32() % 4 == 0) begin
				issue(gen_instr(KIND_MISC));
			end else begin
				issue(gen_instr(KIND_ARITH));
			end
		end
		finish_test("test 2 arithmetic and movhi/orlo");

		// Each conditional branch right behind a compare, PC-relative.
		for (int c = 1; c <= 4; c++) begin
			for (int i = 0; i < 25; i++) begin
				issue(gen_instr(KIND_CMP));
				step(1'b1, gen_branch(4'(c), 1'b0));
			end
		end
		finish_test("test 3 compare and branch");

		for (int i = 0; i < 40; i++) begin
			issue(gen_branch(`OPCODE_CALL, rand32() % 2 == 0));
			// Write a register, then jump through it on the very next cycle.
			w = gen_instr(KIND_ARITH);
			issue(w);
			br = gen_branch(4'd0, 1'b1);
			br[11:8] = w[3:0];
			step(1'b1, br);
		end
		finish_test("test 4 call and branch to Ra");

		for (int i = 0; i < 100; i++) begin
			issue(gen_instr(KIND_MEM));
		end
		finish_test("test 5 loads and stores");

		for (int i = 0; i < 2000; i++) begin
			issue(gen_mixed());
		end
		finish_test("test 6 mixed stream");

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+src
+incdir+verification
src/cpu_pkg.sv
src/cpu_decode.sv
src/cpu_regfile.sv
src/cpu_execute.sv
src/cpu_core.sv
verification/tb_cpu_core.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu_core
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check for a pass"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)
